/* hw/hpp_consts.svh */
// sizes fixed for a 4 KiB page of 64-byte lines; fifo depth must cover the whole page
`ifndef HPP_CONSTS_SVH
`define HPP_CONSTS_SVH

// one cache line per beat
`define HPP_LINE_BITS 512
`define HPP_LINE_BYTES 64

// page geometry
`define HPP_PAGE_LINES 64
`define HPP_OFS_BITS 6   // log2 of page lines

// memory port widths
`define HPP_ADDR_BITS 64
`define HPP_ID_BITS 12   // low bits carry the line offset

// done counter and outstanding counters
`define HPP_CNT_BITS 16

// reads never outrun the queue since a full page fits
`define HPP_FIFO_DEPTH 64

`endif

/* hw/hpp_pkg.sv */
// channel payloads use a valid bit per channel; ready travels as a separate wire
`default_nettype none

`include "hpp_consts.svh"

package hpp_pkg;

    // read address request whose id low bits hold the line offset
    typedef struct packed {
        logic                       valid;
        logic [`HPP_ID_BITS-1:0]    id;
        logic [`HPP_ADDR_BITS-1:0]  addr;
    } ar_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`HPP_ID_BITS-1:0]    id;
        logic [`HPP_LINE_BITS-1:0]  data;   // one full line per response
    } r_rsp_t;

    typedef struct packed {
        logic                       valid;
        logic [`HPP_ID_BITS-1:0]    id;
        logic [`HPP_ADDR_BITS-1:0]  addr;
    } aw_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       last;   // always set for single beat bursts
        logic [`HPP_LINE_BITS-1:0]  data;
    } w_req_t;

    typedef struct packed {
        logic                       valid;
        logic [`HPP_ID_BITS-1:0]    id;
    } b_rsp_t;

    // queued line tagged with its page offset
    typedef struct packed {
        logic [`HPP_OFS_BITS-1:0]   offset;
        logic [`HPP_LINE_BITS-1:0]  data;
    } line_entry_t;

    typedef enum logic {
        RD_IDLE,
        RD_ISSUE
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA
    } wr_state_e;

endpackage

`default_nettype wire

/* hw/hpp_read_engine.sv */
// start must only pulse while idle; r is always accepted, so every return is pushed
`default_nettype none

`include "hpp_consts.svh"

module hpp_read_engine (
    input  logic                        axi4_mm_clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`HPP_ADDR_BITS-1:0]   src_addr,
    input  logic                        ongoing,
    output hpp_pkg::ar_req_t            ar,
    input  logic                        ar_ready,
    input  hpp_pkg::r_rsp_t             r,
    output logic                        push,
    output hpp_pkg::line_entry_t        push_entry,
    output logic                        issue_done
);

    hpp_pkg::rd_state_e         state;
    hpp_pkg::rd_state_e         state_nxt;
    logic [`HPP_ADDR_BITS-1:0]  src_base;   // page base, held for the whole copy
    logic [`HPP_OFS_BITS-1:0]   rd_ofs;     // next line to request
    logic                       ar_fire;
    logic                       last_line;

    assign ar_fire   = ar.valid & ar_ready;
    assign last_line = rd_ofs == `HPP_OFS_BITS'(`HPP_PAGE_LINES - 1);

    always_comb begin
        state_nxt = state;
        case (state)
            hpp_pkg::RD_IDLE: begin
                if (ongoing && !issue_done) begin   // fresh copy, nothing sent yet
                    state_nxt = hpp_pkg::RD_ISSUE;
                end
            end
            hpp_pkg::RD_ISSUE: begin
                if (ar_fire && last_line) begin
                    state_nxt = hpp_pkg::RD_IDLE;
                end
            end
            default: state_nxt = hpp_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            state      <= hpp_pkg::RD_IDLE;
            rd_ofs     <= '0;
            issue_done <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) begin
                rd_ofs     <= '0;       // restart at line 0
                issue_done <= 1'b0;
            end else if (ar_fire) begin
                rd_ofs <= rd_ofs + 1'b1;
                if (last_line) begin
                    issue_done <= 1'b1; // stays up until the next start
                end
            end
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (start) begin
            src_base <= src_addr;
        end
    end

    // request held stable while ar_ready is low, offset only moves on fire
    assign ar.valid = state == hpp_pkg::RD_ISSUE;
    assign ar.id    = `HPP_ID_BITS'(rd_ofs);
    assign ar.addr  = src_base + `HPP_ADDR_BITS'(rd_ofs) * `HPP_LINE_BYTES;

    // r_ready is tied high, so a valid beat is a fire
    assign push              = r.valid;
    assign push_entry.offset = r.id[`HPP_OFS_BITS-1:0];
    assign push_entry.data   = r.data;

endmodule

`default_nettype wire

/* hw/hpp_line_fifo.sv */
// no full flag: depth equals one page, so pushes never overflow; pop only when not empty
`default_nettype none

`include "hpp_consts.svh"

module hpp_line_fifo (
    input  logic                    axi4_mm_clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  hpp_pkg::line_entry_t    push_entry,
    input  logic                    pop,
    output hpp_pkg::line_entry_t    head,
    output logic                    empty
);

    localparam int PTR_BITS = $clog2(`HPP_FIFO_DEPTH);

    hpp_pkg::line_entry_t   mem [`HPP_FIFO_DEPTH];
    logic [PTR_BITS:0]      wr_ptr;     // msb is the wrap bit
    logic [PTR_BITS:0]      rd_ptr;

    // read and write pointers
    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (push) begin
            mem[wr_ptr[PTR_BITS-1:0]] <= push_entry;
        end
    end

    // fall-through head where a push shows up the next cycle
    assign head  = mem[rd_ptr[PTR_BITS-1:0]];
    assign empty = wr_ptr == rd_ptr;   // wrap bits equal too, so not full

endmodule

`default_nettype wire

/* hw/hpp_write_engine.sv */
// single-beat writes; w may go before aw, and a line is popped when its aw fires
`default_nettype none

`include "hpp_consts.svh"

module hpp_write_engine (
    input  logic                        axi4_mm_clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`HPP_ADDR_BITS-1:0]   dst_addr,
    input  hpp_pkg::line_entry_t        head,
    input  logic                        empty,
    output logic                        pop,
    output hpp_pkg::aw_req_t            aw,
    input  logic                        aw_ready,
    output hpp_pkg::w_req_t             w,
    input  logic                        w_ready,
    output logic                        idle
);

    hpp_pkg::wr_state_e         state;
    hpp_pkg::wr_state_e         state_nxt;
    logic [`HPP_ADDR_BITS-1:0]  dst_base;
    logic [`HPP_LINE_BITS-1:0]  wdata_q;    // popped line waiting on w
    logic                       w_sent;     // w already went out ahead of aw
    logic                       aw_fire;
    logic                       w_fire;

    // handshakes fire only in the states that drive the matching valid
    assign aw_fire = (state == hpp_pkg::WR_ADDR) && aw_ready;
    assign w_fire  = (((state == hpp_pkg::WR_ADDR) && !w_sent) ||
                      (state == hpp_pkg::WR_DATA)) && w_ready;

    always_comb begin
        state_nxt = state;
        pop       = 1'b0;
        aw        = '0;
        w         = '0;
        w.last    = 1'b1;       // one beat per line
        w.data    = wdata_q;
        case (state)
            hpp_pkg::WR_IDLE: begin
                if (!empty) begin
                    state_nxt = hpp_pkg::WR_ADDR;
                end
            end
            hpp_pkg::WR_ADDR: begin
                // head is valid here, nothing pops until aw fires
                aw.valid = 1'b1;
                aw.id    = `HPP_ID_BITS'(head.offset);
                aw.addr  = dst_base + `HPP_ADDR_BITS'(head.offset) * `HPP_LINE_BYTES;
                w.valid  = !w_sent;
                w.data   = head.data;
                if (aw_fire) begin
                    pop = 1'b1;
                    if (w_fire || w_sent) begin
                        state_nxt = hpp_pkg::WR_IDLE;   // line done, recheck queue
                    end else begin
                        state_nxt = hpp_pkg::WR_DATA;   // data still owed
                    end
                end
            end
            hpp_pkg::WR_DATA: begin
                w.valid = 1'b1;
                if (w_fire) begin
                    // no pop in this state, so a non-empty head is a fresh line
                    state_nxt = empty ? hpp_pkg::WR_IDLE : hpp_pkg::WR_ADDR;
                end
            end
            default: state_nxt = hpp_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            state  <= hpp_pkg::WR_IDLE;
            w_sent <= 1'b0;
        end else begin
            state <= state_nxt;
            if (aw_fire) begin
                w_sent <= 1'b0;
            end else if ((state == hpp_pkg::WR_ADDR) && w_fire) begin
                w_sent <= 1'b1;     // hold aw alone until it goes
            end
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (start) begin
            dst_base <= dst_addr;
        end
        if (aw_fire) begin
            wdata_q <= head.data;   // copy before the head moves on
        end
    end

    assign idle = state == hpp_pkg::WR_IDLE;

endmodule

`default_nettype wire

/* hw/hpp_done_tracker.sv */
// start is taken as accepted; a zero address only bumps the done count
`default_nettype none

`include "hpp_consts.svh"

module hpp_done_tracker (
    input  logic                        axi4_mm_clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`HPP_ADDR_BITS-1:0]   src_addr,
    input  logic [`HPP_ADDR_BITS-1:0]   dst_addr,
    input  hpp_pkg::ar_req_t            ar,
    input  logic                        ar_ready,
    input  hpp_pkg::r_rsp_t             r,
    input  hpp_pkg::w_req_t             w,
    input  logic                        w_ready,
    input  hpp_pkg::b_rsp_t             b,
    input  logic                        issue_done,
    input  logic                        empty,
    input  logic                        write_idle,
    output logic                        r_ready,
    output logic                        b_ready,
    output logic                        ongoing,
    output logic                        busy,
    output logic [`HPP_CNT_BITS-1:0]    mig_done_cnt
);

    logic [`HPP_CNT_BITS-1:0]   rd_cnt;     // reads issued, not yet returned
    logic [`HPP_CNT_BITS-1:0]   wr_cnt;     // writes sent, not yet acked
    logic                       ar_fire;
    logic                       r_fire;
    logic                       w_fire;
    logic                       b_fire;
    logic                       zero_start;
    logic                       copy_end;

    assign r_ready = 1'b1;     // responses always sink
    assign b_ready = 1'b1;

    assign ar_fire = ar.valid & ar_ready;
    assign r_fire  = r.valid & r_ready;
    assign w_fire  = w.valid & w_ready;
    assign b_fire  = b.valid & b_ready;

    assign zero_start = start && ((src_addr == '0) || (dst_addr == '0));   // control command
    assign copy_end   = ongoing && issue_done && (rd_cnt == '0) && (wr_cnt == '0) &&
                        empty && write_idle;

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            rd_cnt       <= '0;
            wr_cnt       <= '0;
            ongoing      <= 1'b0;
            mig_done_cnt <= '0;
        end else begin
            if (ar_fire && !r_fire) begin
                rd_cnt <= rd_cnt + 1'b1;
            end else if (!ar_fire && r_fire) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
            if (w_fire && !b_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end else if (!w_fire && b_fire) begin
                wr_cnt <= wr_cnt - 1'b1;
            end
            if (start && !zero_start) begin
                ongoing <= 1'b1;
            end
            if (copy_end) begin
                ongoing <= 1'b0;   // busy drops with the count step
            end
            if (copy_end || zero_start) begin
                mig_done_cnt <= mig_done_cnt + 1'b1;
            end
        end
    end

    assign busy = ongoing;

endmodule

`default_nettype wire

/* hw/hot_page_pusher.sv */
// one page copy at a time; a start while busy is dropped and r/b are never back-pressured
`default_nettype none

`include "hpp_consts.svh"

module hot_page_pusher (
    input  logic                        axi4_mm_clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`HPP_ADDR_BITS-1:0]   src_addr,
    input  logic [`HPP_ADDR_BITS-1:0]   dst_addr,
    output hpp_pkg::ar_req_t            ar,
    input  logic                        ar_ready,
    input  hpp_pkg::r_rsp_t             r,
    output logic                        r_ready,
    output hpp_pkg::aw_req_t            aw,
    input  logic                        aw_ready,
    output hpp_pkg::w_req_t             w,
    input  logic                        w_ready,
    input  hpp_pkg::b_rsp_t             b,
    output logic                        b_ready,
    output logic [`HPP_CNT_BITS-1:0]    mig_done_cnt,
    output logic                        busy
);

    logic                   start_acc;      // start seen while idle
    logic                   ongoing;
    logic                   issue_done;
    logic                   push;
    logic                   pop;
    logic                   empty;
    logic                   write_idle;
    hpp_pkg::line_entry_t   push_entry;
    hpp_pkg::line_entry_t   head;

    assign start_acc = start & ~busy;

    hpp_read_engine u_read_engine (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .start       (start_acc),
        .src_addr    (src_addr),
        .ongoing     (ongoing),
        .ar          (ar),
        .ar_ready    (ar_ready),
        .r           (r),
        .push        (push),
        .push_entry  (push_entry),
        .issue_done  (issue_done)
    );

    hpp_line_fifo u_line_fifo (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_entry  (push_entry),
        .pop         (pop),
        .head        (head),
        .empty       (empty)
    );

    hpp_write_engine u_write_engine (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .start       (start_acc),
        .dst_addr    (dst_addr),
        .head        (head),
        .empty       (empty),
        .pop         (pop),
        .aw          (aw),
        .aw_ready    (aw_ready),
        .w           (w),
        .w_ready     (w_ready),
        .idle        (write_idle)
    );

    hpp_done_tracker u_done_tracker (
        .axi4_mm_clk  (axi4_mm_clk),
        .rst_n        (rst_n),
        .start        (start_acc),
        .src_addr     (src_addr),
        .dst_addr     (dst_addr),
        .ar           (ar),
        .ar_ready     (ar_ready),
        .r            (r),
        .w            (w),
        .w_ready      (w_ready),
        .b            (b),
        .issue_done   (issue_done),
        .empty        (empty),
        .write_idle   (write_idle),
        .r_ready      (r_ready),
        .b_ready      (b_ready),
        .ongoing      (ongoing),
        .busy         (busy),
        .mig_done_cnt (mig_done_cnt)
    );

endmodule

`default_nettype wire

/* bench/tb_hot_page_pusher.sv */
// runs from the project root; needs bench/hpp_stim.txt and expects page-aligned copy addresses
`default_nettype none

`include "hpp_consts.svh"

module tb_hot_page_pusher;

    localparam int PAGE_BYTES = `HPP_PAGE_LINES * `HPP_LINE_BYTES;

    typedef logic [`HPP_LINE_BITS+15:0] chk_t;    // wide enough for any payload

    logic                       axi4_mm_clk;
    logic                       rst_n;
    logic                       start;
    logic [`HPP_ADDR_BITS-1:0]  src_addr;
    logic [`HPP_ADDR_BITS-1:0]  dst_addr;
    hpp_pkg::ar_req_t           ar;
    logic                       ar_ready;
    hpp_pkg::r_rsp_t            r;
    logic                       r_ready;
    hpp_pkg::aw_req_t           aw;
    logic                       aw_ready;
    hpp_pkg::w_req_t            w;
    logic                       w_ready;
    hpp_pkg::b_rsp_t            b;
    logic                       b_ready;
    logic [`HPP_CNT_BITS-1:0]   mig_done_cnt;
    logic                       busy;

    // commands as read from the stim file
    logic [`HPP_ADDR_BITS-1:0]  cmd_src [$];
    logic [`HPP_ADDR_BITS-1:0]  cmd_dst [$];
    logic [31:0]                cmd_stall [$];
    logic [`HPP_CNT_BITS-1:0]   cmd_done [$];

    // memory model
    integer                     seed;
    logic [31:0]                stall_pct;          // percent of cycles a ready is low
    logic [`HPP_ADDR_BITS-1:0]  cur_src;
    logic [`HPP_ADDR_BITS-1:0]  cur_dst;
    logic [`HPP_ADDR_BITS-1:0]  rd_addr_q [$];      // reads waiting for their reply
    logic [`HPP_ID_BITS-1:0]    rd_id_q [$];
    int                         rd_due_q [$];
    logic [`HPP_ADDR_BITS-1:0]  aw_q [$];           // aw and w may arrive in either order
    logic [`HPP_LINE_BITS-1:0]  w_q [$];
    logic [`HPP_LINE_BITS-1:0]  dst_mem [logic [`HPP_ADDR_BITS-1:0]];
    logic [`HPP_ADDR_BITS-1:0]  wr_addr;
    logic                       ar_fire, aw_fire, w_fire, r_fire, b_fire;
    logic                       ar_wait, aw_wait, w_wait;   // valid seen without ready
    hpp_pkg::ar_req_t           ar_hold;
    hpp_pkg::aw_req_t           aw_hold;
    hpp_pkg::w_req_t            w_hold;
    logic [31:0]                rnd;
    int                         reads_out;
    int                         writes_out;
    int                         rd_total;
    int                         wr_total;
    int                         mdl_cycle;
    int                         cycle_cnt;
    int                         timeout_cycles;

    hot_page_pusher UUT (.*);

    initial begin
        axi4_mm_clk = 1'b0;
        forever #10 axi4_mm_clk = ~axi4_mm_clk;
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input chk_t expected, input chk_t actual);
        if (expected !== actual) begin
            $display("** Error at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    // each word is one half of the line address xored with its word index
    function automatic logic [`HPP_LINE_BITS-1:0] line_pattern(
        input logic [`HPP_ADDR_BITS-1:0] addr);
        logic [`HPP_LINE_BITS-1:0] line;
        for (int i = 0; i < `HPP_LINE_BITS / 32; i++) begin
            line[i*32 +: 32] = addr[(i % 2)*32 +: 32] ^ 32'(i);   // low half on even words
        end
        return line;
    endfunction

    function automatic logic ready_draw();
        logic [31:0] draw;
        draw = $random(seed);
        return (draw % 32'd100) >= stall_pct;     // low for stall_pct percent of cycles
    endfunction

    task automatic read_stim();
        int                         fd;
        int                         code;
        string                      line;
        logic [`HPP_ADDR_BITS-1:0]  s;
        logic [`HPP_ADDR_BITS-1:0]  d;
        logic [31:0]                pct;
        logic [31:0]                cnt;
        fd = $fopen("bench/hpp_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/hpp_stim.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                if ($sscanf(line, "%h %h %d %d", s, d, pct, cnt) != 4) begin
                    $display("malformed stimulus line: %s", line);
                    stop_run();
                end
                cmd_src.push_back(s);
                cmd_dst.push_back(d);
                cmd_stall.push_back(pct);
                cmd_done.push_back(cnt[`HPP_CNT_BITS-1:0]);
            end
        end
        $fclose(fd);
        if (cmd_src.size() == 0) begin
            $display("stimulus file holds no commands");
            stop_run();
        end
    endtask

    // whole destination page against the source rule, line by line
    task automatic check_page(input logic [`HPP_ADDR_BITS-1:0] src,
                              input logic [`HPP_ADDR_BITS-1:0] dst);
        logic [`HPP_ADDR_BITS-1:0] addr;
        for (int o = 0; o < `HPP_PAGE_LINES; o++) begin
            addr = dst + 64'(o) * `HPP_LINE_BYTES;
            if (!dst_mem.exists(addr)) begin
                $display("destination line %0d at %0h was never written", o, addr);
                stop_run();
            end
            check_value("written line data",
                        chk_t'(line_pattern(src + 64'(o) * `HPP_LINE_BYTES)),
                        chk_t'(dst_mem[addr]));
        end
    endtask

    task automatic run_command(input int idx);
        logic [`HPP_CNT_BITS-1:0]   prev_cnt;
        logic                       copy;
        copy      = (cmd_src[idx] != '0) && (cmd_dst[idx] != '0);
        stall_pct = cmd_stall[idx];
        cur_src   = cmd_src[idx];
        cur_dst   = cmd_dst[idx];
        rd_total  = 0;
        wr_total  = 0;
        dst_mem.delete();
        @(posedge axi4_mm_clk);
        #2;
        check_value("mig_done_cnt", chk_t'(cmd_done[idx] - 1'b1), chk_t'(mig_done_cnt));
        start    = 1'b1;
        src_addr = cmd_src[idx];
        dst_addr = cmd_dst[idx];
        @(posedge axi4_mm_clk);
        #2;
        start = 1'b0;
        @(negedge axi4_mm_clk);
        if (copy) begin
            check_value("busy", chk_t'(1'b1), chk_t'(busy));   // up one cycle after start
            while (busy) begin
                prev_cnt = mig_done_cnt;
                @(negedge axi4_mm_clk);             // watchdog bounds this wait
            end
            check_value("mig_done_cnt", chk_t'(cmd_done[idx] - 1'b1), chk_t'(prev_cnt));
            check_value("mig_done_cnt", chk_t'(cmd_done[idx]), chk_t'(mig_done_cnt));
            check_value("outstanding reads", '0, chk_t'(reads_out));
            check_value("outstanding writes", '0, chk_t'(writes_out));
            check_value("read count", chk_t'(`HPP_PAGE_LINES), chk_t'(rd_total));
            check_value("write count", chk_t'(`HPP_PAGE_LINES), chk_t'(wr_total));
            check_page(cmd_src[idx], cmd_dst[idx]);
        end else begin
            // control command steps the count next cycle with no traffic at all
            repeat (4) begin
                check_value("mig_done_cnt", chk_t'(cmd_done[idx]), chk_t'(mig_done_cnt));
                check_value("busy", '0, chk_t'(busy));
                check_value("ar.valid", '0, chk_t'(ar.valid));
                check_value("aw.valid", '0, chk_t'(aw.valid));
                @(negedge axi4_mm_clk);
            end
            check_value("read count", '0, chk_t'(rd_total));
            check_value("write count", '0, chk_t'(wr_total));
        end
        repeat (2) @(negedge axi4_mm_clk);
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        src_addr = '0;
        dst_addr = '0;
        read_stim();
        timeout_cycles = cmd_src.size() * 3000;
        repeat (10) @(posedge axi4_mm_clk);
        #2;
        rst_n = 1'b1;
        repeat (3) begin                            // quiet after reset, before any start
            @(negedge axi4_mm_clk);
            check_value("ar.valid", '0, chk_t'(ar.valid));
            check_value("aw.valid", '0, chk_t'(aw.valid));
            check_value("w.valid", '0, chk_t'(w.valid));
            check_value("busy", '0, chk_t'(busy));
            check_value("mig_done_cnt", '0, chk_t'(mig_done_cnt));
            check_value("r_ready", chk_t'(1'b1), chk_t'(r_ready));
            check_value("b_ready", chk_t'(1'b1), chk_t'(b_ready));
        end
        for (int i = 0; i < cmd_src.size(); i++) begin
            run_command(i);
        end
        $display("Everything OK");
        $finish;
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        do begin
            @(posedge axi4_mm_clk);
            cycle_cnt++;
        end while (cycle_cnt <= timeout_cycles);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        stop_run();
    end

    // sample at negedge, update and drive 2 units after posedge
    initial begin
        seed       = 32'h5fe1_1b5c;
        stall_pct  = '0;
        ar_ready   = 1'b0;
        aw_ready   = 1'b0;
        w_ready    = 1'b0;
        r          = '0;
        b          = '0;
        ar_wait    = 1'b0;
        aw_wait    = 1'b0;
        w_wait     = 1'b0;
        reads_out  = 0;
        writes_out = 0;
        mdl_cycle  = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge axi4_mm_clk);
            if (ar_wait) check_value("ar", chk_t'(ar_hold), chk_t'(ar));   // held payload
            if (aw_wait) check_value("aw", chk_t'(aw_hold), chk_t'(aw));
            if (w_wait) check_value("w", chk_t'(w_hold), chk_t'(w));
            ar_fire = ar.valid && ar_ready;
            aw_fire = aw.valid && aw_ready;
            w_fire  = w.valid && w_ready;
            r_fire  = r.valid;                      // r_ready is tied high
            b_fire  = b.valid;
            ar_wait = ar.valid && !ar_ready;
            aw_wait = aw.valid && !aw_ready;
            w_wait  = w.valid && !w_ready;
            ar_hold = ar;
            aw_hold = aw;
            w_hold  = w;
            @(posedge axi4_mm_clk);
            #2;
            mdl_cycle++;
            if (r_fire) begin
                void'(rd_addr_q.pop_front());
                void'(rd_id_q.pop_front());
                void'(rd_due_q.pop_front());
                reads_out--;
            end
            if (ar_fire) begin                      // reads go out in offset order
                check_value("ar.addr", chk_t'(cur_src + 64'(rd_total) * `HPP_LINE_BYTES),
                            chk_t'(ar_hold.addr));
                check_value("ar.id", chk_t'(rd_total), chk_t'(ar_hold.id));
                rnd = $random(seed);
                rd_addr_q.push_back(ar_hold.addr);
                rd_id_q.push_back(ar_hold.id);
                rd_due_q.push_back(mdl_cycle + 1 + int'(rnd[1:0]));  // 1 to 4 cycles
                reads_out++;
                rd_total++;
            end
            if (aw_fire) begin
                wr_addr = aw_hold.addr - cur_dst;   // only line-aligned bits inside a page
                check_value("aw.addr page offset", chk_t'(wr_addr & 64'(PAGE_BYTES - 64)),
                            chk_t'(wr_addr));
                aw_q.push_back(aw_hold.addr);
            end
            if (w_fire) begin
                check_value("w.last", chk_t'(1'b1), chk_t'(w_hold.last));
                w_q.push_back(w_hold.data);
                writes_out++;
            end
            if (b_fire) writes_out--;
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                wr_addr = aw_q.pop_front();
                if (dst_mem.exists(wr_addr)) begin
                    $display("destination line %0h written more than once", wr_addr);
                    stop_run();
                end
                dst_mem[wr_addr] = w_q.pop_front();
                wr_total++;
            end
            r = '0;
            if (rd_due_q.size() > 0 && rd_due_q[0] <= mdl_cycle) begin
                r.valid = 1'b1;
                r.id    = rd_id_q[0];
                r.data  = line_pattern(rd_addr_q[0]);
            end
            b.valid  = w_fire;                      // ack one cycle after w
            b.id     = '0;
            ar_ready = ready_draw();
            aw_ready = ready_draw();
            w_ready  = ready_draw();
        end
    end

endmodule

`default_nettype wire

/* hot_page_pusher.f */
+incdir+hw
hw/hpp_pkg.sv
hw/hpp_read_engine.sv
hw/hpp_line_fifo.sv
hw/hpp_write_engine.sv
hw/hpp_done_tracker.sv
hw/hot_page_pusher.sv
bench/tb_hot_page_pusher.sv

/* Makefile */
BIN  := obj_dir/Vtb_hot_page_pusher
SRCS := hot_page_pusher.f $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_hot_page_pusher -f hot_page_pusher.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

/* bench/hpp_stim.txt */
// src_addr (hex)   dst_addr (hex)   stall_pct (dec)   expected mig_done_cnt (dec)
// a zero address makes the line a control command with no traffic
0000000000010000 0000000000020000 0 1
0000000000000000 0000000000030000 0 2
0000000000031000 0000000000000000 0 3
00000000abcd0000 0000000012345000 25 4
0000000100000000 0000000000050000 50 5
0000000000000000 0000000000000000 10 6
00007fff00004000 0000000000ffe000 70 7
0000000000020000 0000000000010000 0 8
